// File: Bender.yml
package:
  name: btb_target

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/btb_pkg.sv
      - hw/upct_if.sv
      - hw/pe_lsb.sv
      - hw/upct.sv
      - hw/btb_array.sv
      - hw/btb_target_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - test/btb_target_checker.sv
      - test/btb_target_tb.sv

// File: btb_target_top.f
+incdir+hw
hw/btb_pkg.sv
hw/upct_if.sv
hw/pe_lsb.sv
hw/upct.sv
hw/btb_array.sv
hw/btb_target_top.sv
test/btb_target_checker.sv
test/btb_target_tb.sv

// File: hw/btb_array.sv
// Direct-mapped BTB storage for branch targets.
// Lookups run REQ then RESP; writes get their UPCT index one cycle after
// the target is sent to the table.

`default_nettype none

`include "btb_cfg.svh"

module btb_array import btb_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,

    // lookup
    input  logic        req_valid,
    input  logic [31:0] req_fetch_pc,
    output logic        resp_valid,
    output logic        resp_hit,
    output logic [31:0] resp_target_pc,

    // update from branch resolution
    input  btb_op_e     update_op,
    input  logic [31:0] update_fetch_pc,
    input  logic [31:0] update_target_pc,

    upct_if.client      upct
);

    // ----------------------------------------
    // signals

    btb_entry_t btb_mem [`BTB_ENTRIES];

    // REQ stage
    logic [`LOG_BTB_ENTRIES-1:0] req_index;
    btb_tag_t                    req_tag;

    // RESP stage
    logic                        resp_valid_q;
    btb_entry_t                  resp_entry;
    btb_tag_t                    resp_tag;

    // update pipeline
    btb_op_e                     update1_op;
    logic [`LOG_BTB_ENTRIES-1:0] update1_btb_index;
    btb_tag_t                    update1_tag;
    lower_pc_t                   update1_lower_pc;

    // ----------------------------------------
    // REQ stage

    // skip the two byte-offset bits
    assign req_index = req_fetch_pc[`LOG_BTB_ENTRIES+1:2];
    assign req_tag   = req_fetch_pc[`BTB_TAG_WIDTH+`LOG_BTB_ENTRIES+1:`LOG_BTB_ENTRIES+2];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= req_valid;
        end
    end

    always_ff @(posedge CLK) begin
        resp_entry <= btb_mem[req_index];
        resp_tag   <= req_tag;
    end

    // ----------------------------------------
    // RESP stage

    assign resp_valid = resp_valid_q;
    assign resp_hit   = resp_valid_q && resp_entry.valid && (resp_entry.tag == resp_tag);

    // a hit touches the UPCT PLRU
    assign upct.valid_resp = resp_hit;
    assign upct.index_resp = resp_entry.upct_index;

    // upper region from the table joined with stored low bits
    assign resp_target_pc = {upct.upper_pc_resp, resp_entry.lower_pc};

    // ----------------------------------------
    // update 0, send target region to the table

    assign upct.update0_valid    = (update_op == BTB_OP_WRITE);
    assign upct.update0_start_pc = update_target_pc;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            update1_op <= BTB_OP_NONE;
        end else begin
            update1_op <= update_op;
        end
    end

    always_ff @(posedge CLK) begin
        update1_btb_index <= update_fetch_pc[`LOG_BTB_ENTRIES+1:2];
        update1_tag       <= update_fetch_pc[`BTB_TAG_WIDTH+`LOG_BTB_ENTRIES+1:
                                             `LOG_BTB_ENTRIES+2];
        update1_lower_pc  <= update_target_pc[`LOWER_PC_WIDTH-1:0];
    end

    // ----------------------------------------
    // update 1, entry write with the table's index

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                btb_mem[i] <= '0;
            end
        end else if (update1_op == BTB_OP_WRITE) begin
            btb_mem[update1_btb_index] <= '{
                valid:      1'b1,
                tag:        update1_tag,
                lower_pc:   update1_lower_pc,
                upct_index: upct.update1_index
            };
        end else if (update1_op == BTB_OP_INVALIDATE) begin
            // UPCT is left alone
            btb_mem[update1_btb_index].valid <= 1'b0;
        end
    end

    // ----------------------------------------
    // checks

    a_update_op_known: assert property (@(posedge CLK) disable iff (!nRST)
        !$isunknown(update_op))
        else $error("btb_array: update_op unknown out of reset");

endmodule

`default_nettype wire

// File: hw/btb_cfg.svh
// Size settings for the BTB target path and its upper PC table.
// Included by the package and by any RTL file that needs the raw sizes.

`ifndef BTB_CFG_SVH
`define BTB_CFG_SVH

// upper PC table
`define UPCT_ENTRIES 8
`define LOG_UPCT_ENTRIES 3

// PC split between upper region and stored low bits
`define UPPER_PC_WIDTH 22
`define LOWER_PC_WIDTH 10

// direct-mapped BTB, index from fetch PC bits 5..2
`define BTB_ENTRIES 16
`define LOG_BTB_ENTRIES 4

// tag from fetch PC bits 13..6
`define BTB_TAG_WIDTH 8

`endif

// File: hw/btb_pkg.sv
// Types shared by the BTB target path: PC parts, BTB entry layout and
// the update opcodes. Imported by wildcard in the module headers.

`default_nettype none

`include "btb_cfg.svh"

package btb_pkg;

    // ----------------------------------------
    // index and PC pieces

    typedef logic [`LOG_UPCT_ENTRIES-1:0] upct_index_t;
    typedef logic [`UPPER_PC_WIDTH-1:0]   upper_pc_t;
    typedef logic [`LOWER_PC_WIDTH-1:0]   lower_pc_t;
    typedef logic [`BTB_TAG_WIDTH-1:0]    btb_tag_t;

    // ----------------------------------------
    // BTB entry, 22 bits

    typedef struct packed {
        logic        valid;
        btb_tag_t    tag;
        // low target bits, upper bits come from the UPCT
        lower_pc_t   lower_pc;
        upct_index_t upct_index;
    } btb_entry_t;

    // ----------------------------------------
    // update opcodes from branch resolution

    typedef enum logic [1:0] {
        BTB_OP_NONE       = 2'b00,
        BTB_OP_WRITE      = 2'b01,
        BTB_OP_INVALIDATE = 2'b10
    } btb_op_e;

endpackage

`default_nettype wire

// File: hw/btb_target_top.sv
// Top of the BTB target path: the entry array and the shared upper PC
// table joined through upct_if. Lookups answer one cycle after REQ,
// writes land at the end of the cycle after they are presented.

`default_nettype none

module btb_target_top import btb_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,

    // fetch lookup
    input  logic        req_valid,
    input  logic [31:0] req_fetch_pc,
    output logic        resp_valid,
    output logic        resp_hit,
    output logic [31:0] resp_target_pc,

    // branch resolution update
    input  btb_op_e     update_op,
    input  logic [31:0] update_fetch_pc,
    input  logic [31:0] update_target_pc
);

    // ----------------------------------------
    // array to table link

    upct_if u_upct_if ();

    btb_array u_btb_array (
        .CLK             (CLK),
        .nRST            (nRST),
        .req_valid       (req_valid),
        .req_fetch_pc    (req_fetch_pc),
        .resp_valid      (resp_valid),
        .resp_hit        (resp_hit),
        .resp_target_pc  (resp_target_pc),
        .update_op       (update_op),
        .update_fetch_pc (update_fetch_pc),
        .update_target_pc(update_target_pc),
        .upct            (u_upct_if.client)
    );

    // shared upper regions
    upct u_upct (
        .CLK (CLK),
        .nRST(nRST),
        .tbl (u_upct_if.tbl)
    );

endmodule

`default_nettype wire

// File: hw/pe_lsb.sv
// Priority encoder giving the position of the lowest set request bit.
// Returns 0 when no bit is set, so callers check the OR of req_vec.

`default_nettype none

module pe_lsb #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         req_vec,
    output logic [$clog2(WIDTH)-1:0] ack_index
);

    // scan from the top so the lowest set bit wins
    always_comb begin
        ack_index = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                ack_index = $clog2(WIDTH)'(i);
            end
        end
    end

    // ----------------------------------------
    // checks

    // encoded index must point at a requesting bit
    a_ack_is_set: assert final (!(|req_vec) || req_vec[ack_index])
        else $error("pe_lsb: ack_index %0d not set in req_vec %b", ack_index, req_vec);

endmodule

`default_nettype wire

// File: hw/upct.sv
// Upper PC table: 8 shared upper target regions with tree-PLRU replacement.
// RESP reads are combinational; updates search in stage 0 and resolve to
// a matching index or a freshly filled victim in stage 1.

`default_nettype none

`include "btb_cfg.svh"

module upct import btb_pkg::*; (
    input logic CLK,
    input logic nRST,

    upct_if.tbl tbl
);

    // ----------------------------------------
    // state

    upper_pc_t upct_array [`UPCT_ENTRIES];

    // tree PLRU, root picks bit 2, mid bit 1, leaf bit 0
    logic       plru_root, next_plru_root;
    logic [1:0] plru_mid, next_plru_mid;
    logic [3:0] plru_leaf, next_plru_leaf;

    // update 0
    upper_pc_t                 update0_upper_pc;
    logic [`UPCT_ENTRIES-1:0]  update0_match_vec;

    // update 1
    logic                      update1_valid;
    upper_pc_t                 update1_upper_pc;
    logic [`UPCT_ENTRIES-1:0]  update1_match_vec;
    logic                      update1_have_match;
    upct_index_t               match_index;
    upct_index_t               victim_index;
    upct_index_t               update1_index;

    // PLRU touch selection
    logic                      touch_en;
    upct_index_t               touch_index;

    // ----------------------------------------
    // update 0 CAM search

    assign update0_upper_pc = tbl.update0_start_pc[31 -: `UPPER_PC_WIDTH];

    // unwritten entries hold region 0 after reset
    always_comb begin
        for (int i = 0; i < `UPCT_ENTRIES; i++) begin
            update0_match_vec[i] = (upct_array[i] == update0_upper_pc);
        end
    end

    // ----------------------------------------
    // update 1 and RESP

    assign tbl.upper_pc_resp = upct_array[tbl.index_resp];

    assign update1_have_match = |update1_match_vec;

    pe_lsb #(
        .WIDTH(`UPCT_ENTRIES)
    ) u_match_pe (
        .req_vec  (update1_match_vec),
        .ack_index(match_index)
    );

    // follow the tree from the root down
    assign victim_index = {plru_root, plru_mid[plru_root],
                           plru_leaf[{plru_root, plru_mid[plru_root]}]};

    // priority: update 1 hit, update 1 miss, RESP touch
    always_comb begin
        update1_index = victim_index;
        touch_en      = 1'b0;
        touch_index   = victim_index;

        if (update1_valid && update1_have_match) begin
            update1_index = match_index;
            touch_en      = 1'b1;
            touch_index   = match_index;
        end else if (update1_valid) begin
            touch_en      = 1'b1;
        end else if (tbl.valid_resp) begin
            touch_en      = 1'b1;
            touch_index   = tbl.index_resp;
        end
    end

    assign tbl.update1_index = update1_index;

    // point every bit on the touched path away from it
    always_comb begin
        next_plru_root = plru_root;
        next_plru_mid  = plru_mid;
        next_plru_leaf = plru_leaf;

        if (touch_en) begin
            next_plru_root                   = ~touch_index[2];
            next_plru_mid[touch_index[2]]    = ~touch_index[1];
            next_plru_leaf[touch_index[2:1]] = ~touch_index[0];
        end
    end

    // ----------------------------------------
    // registers

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `UPCT_ENTRIES; i++) begin
                upct_array[i] <= '0;
            end
            plru_root     <= 1'b0;
            plru_mid      <= '0;
            plru_leaf     <= '0;
            update1_valid <= 1'b0;
        end else begin
            // fill the victim on an update 1 miss
            if (update1_valid && !update1_have_match) begin
                upct_array[victim_index] <= update1_upper_pc;
            end
            plru_root     <= next_plru_root;
            plru_mid      <= next_plru_mid;
            plru_leaf     <= next_plru_leaf;
            update1_valid <= tbl.update0_valid;
        end
    end

    always_ff @(posedge CLK) begin
        update1_upper_pc  <= update0_upper_pc;
        update1_match_vec <= update0_match_vec;
    end

    // ----------------------------------------
    // checks

    // regions stay unique while writes to one region are spaced out
    a_match_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        update1_valid |-> $onehot0(update1_match_vec))
        else $error("upct: region found in more than one entry %b", update1_match_vec);

    // the BTB stores this index on the same edge
    a_index_known: assert property (@(posedge CLK) disable iff (!nRST)
        update1_valid |-> !$isunknown(tbl.update1_index))
        else $error("upct: update1_index unknown during update 1");

endmodule

`default_nettype wire

// File: hw/upct_if.sv
// Signals between the BTB array and the upper PC table.
// The table side reads lookups and updates, the client side drives them.

`default_nettype none

interface upct_if import btb_pkg::*; ();

    // RESP stage, hit touches the PLRU
    logic        valid_resp;
    upct_index_t index_resp;
    upper_pc_t   upper_pc_resp;

    // update 0, full 32-bit target
    logic        update0_valid;
    logic [31:0] update0_start_pc;

    // update 1, one cycle after update0_valid
    upct_index_t update1_index;

    modport tbl (
        input  valid_resp,
        input  index_resp,
        output upper_pc_resp,
        input  update0_valid,
        input  update0_start_pc,
        output update1_index
    );

    modport client (
        output valid_resp,
        output index_resp,
        input  upper_pc_resp,
        output update0_valid,
        output update0_start_pc,
        input  update1_index
    );

endinterface

`default_nettype wire

// File: test/btb_target_checker.sv
// Reference model of the BTB target path for the testbench.
// Samples the DUT ports on the falling clock edge, keeps its own BTB and
// upper PC table with tree PLRU, and compares every lookup response.

`default_nettype none

`include "btb_cfg.svh"

module btb_target_checker import btb_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        req_valid,
    input  logic [31:0] req_fetch_pc,
    input  btb_op_e     update_op,
    input  logic [31:0] update_fetch_pc,
    input  logic [31:0] update_target_pc,
    input  logic        resp_valid,
    input  logic        resp_hit,
    input  logic [31:0] resp_target_pc,
    output int          error_count,
    output int          check_count
);

    // ----------------------------------------
    // model state

    btb_entry_t  m_btb [`BTB_ENTRIES];
    upper_pc_t   m_upct [`UPCT_ENTRIES];
    logic        m_root;
    logic [1:0]  m_mid;
    logic [3:0]  m_leaf;

    // lookup waiting for its RESP cycle
    logic        p_req_valid;
    btb_entry_t  p_entry;
    btb_tag_t    p_tag;

    // update waiting for stage 1, CAM result taken in stage 0
    btb_op_e     p_op;
    logic [3:0]  p_index;
    btb_tag_t    p_wtag;
    lower_pc_t   p_lower;
    upper_pc_t   p_upper;
    logic        p_found;
    upct_index_t p_found_index;

    // walk the tree from the root down
    function automatic upct_index_t plru_victim();
        plru_victim = {m_root, m_mid[m_root], m_leaf[{m_root, m_mid[m_root]}]};
    endfunction

    // every bit on the path now points away from idx
    task automatic plru_touch(input upct_index_t idx);
        m_root           = ~idx[2];
        m_mid[idx[2]]    = ~idx[1];
        m_leaf[idx[2:1]] = ~idx[0];
    endtask

    task automatic clear_model();
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            m_btb[i] = '0;
        end
        for (int i = 0; i < `UPCT_ENTRIES; i++) begin
            m_upct[i] = '0;
        end
        m_root      = 1'b0;
        m_mid       = '0;
        m_leaf      = '0;
        p_req_valid = 1'b0;
        p_entry     = '0;
        p_op        = BTB_OP_NONE;
    endtask

    // ----------------------------------------
    // one cycle of the model

    always @(negedge CLK) begin : model_step
        logic        exp_hit;
        logic [31:0] exp_target;
        upct_index_t wr_index;
        logic        n_found;
        upct_index_t n_found_index;
        btb_entry_t  n_entry;

        if (!nRST) begin
            clear_model();
            check_count++;
            if (resp_valid !== 1'b0 || resp_hit !== 1'b0) begin
                error_count++;
                $display("ERROR @%0t: response active while reset is held", $time);
            end
        end else begin
            // RESP of the lookup from the previous cycle
            exp_hit    = p_req_valid && p_entry.valid && (p_entry.tag == p_tag);
            exp_target = {m_upct[p_entry.upct_index], p_entry.lower_pc};
            if (p_req_valid) begin
                check_count++;
            end
            if (resp_valid !== p_req_valid) begin
                error_count++;
                $display("ERROR @%0t: resp_valid %b, expected %b", $time,
                         resp_valid, p_req_valid);
            end else if (p_req_valid && resp_hit !== exp_hit) begin
                error_count++;
                $display("ERROR @%0t: resp_hit %b, expected %b (tag %h)", $time,
                         resp_hit, exp_hit, p_tag);
            end else if (exp_hit && resp_target_pc !== exp_target) begin
                error_count++;
                $display("ERROR @%0t: resp_target_pc %h, expected %h", $time,
                         resp_target_pc, exp_target);
            end

            // stage 0 search and REQ read see the table before this cycle's write
            n_found       = 1'b0;
            n_found_index = '0;
            for (int i = `UPCT_ENTRIES - 1; i >= 0; i--) begin
                if (m_upct[i] == update_target_pc[31:10]) begin
                    n_found       = 1'b1;
                    n_found_index = upct_index_t'(i);
                end
            end
            n_entry = m_btb[req_fetch_pc[5:2]];

            // stage 1 write wins the PLRU over a RESP touch
            if (p_op == BTB_OP_WRITE) begin
                wr_index = p_found ? p_found_index : plru_victim();
                if (!p_found) begin
                    m_upct[wr_index] = p_upper;
                end
                plru_touch(wr_index);
                m_btb[p_index] = '{1'b1, p_wtag, p_lower, wr_index};
            end else begin
                if (p_op == BTB_OP_INVALIDATE) begin
                    m_btb[p_index].valid = 1'b0;
                end
                if (exp_hit) begin
                    plru_touch(p_entry.upct_index);
                end
            end

            p_req_valid   = req_valid;
            p_entry       = n_entry;
            p_tag         = req_fetch_pc[13:6];
            p_op          = update_op;
            p_index       = update_fetch_pc[5:2];
            p_wtag        = update_fetch_pc[13:6];
            p_lower       = update_target_pc[9:0];
            p_upper       = update_target_pc[31:10];
            p_found       = n_found;
            p_found_index = n_found_index;
        end
    end

endmodule

`default_nettype wire

// File: test/btb_target_tb.sv
// Testbench for the BTB target path. A table of lookups, writes and
// invalidates is applied one entry per cycle; btb_target_checker compares
// the responses and this module reports each test and the final result.

`default_nettype none

module btb_target_tb import btb_pkg::*; ();

    typedef enum int {
        STIM_IDLE,
        STIM_LOOKUP,
        STIM_WRITE,
        STIM_INVAL,
        STIM_FILL
    } stim_op_e;

    typedef struct {
        int          test;
        stim_op_e    op;
        logic [31:0] pc;
        logic [31:0] target;
    } stim_t;

    logic        CLK = 1'b0;
    logic        nRST;
    logic        req_valid;
    logic [31:0] req_fetch_pc;
    logic        resp_valid;
    logic        resp_hit;
    logic [31:0] resp_target_pc;
    btb_op_e     update_op;
    logic [31:0] update_fetch_pc;
    logic [31:0] update_target_pc;

    int          error_count;
    int          check_count;
    stim_t       stim_q [$];
    int          seed = 8793;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          errors_before = 0;
    int          checks_before = 0;

    btb_target_top u_dut (
        .CLK             (CLK),
        .nRST            (nRST),
        .req_valid       (req_valid),
        .req_fetch_pc    (req_fetch_pc),
        .resp_valid      (resp_valid),
        .resp_hit        (resp_hit),
        .resp_target_pc  (resp_target_pc),
        .update_op       (update_op),
        .update_fetch_pc (update_fetch_pc),
        .update_target_pc(update_target_pc)
    );

    btb_target_checker u_checker (
        .CLK             (CLK),
        .nRST            (nRST),
        .req_valid       (req_valid),
        .req_fetch_pc    (req_fetch_pc),
        .update_op       (update_op),
        .update_fetch_pc (update_fetch_pc),
        .update_target_pc(update_target_pc),
        .resp_valid      (resp_valid),
        .resp_hit        (resp_hit),
        .resp_target_pc  (resp_target_pc),
        .error_count     (error_count),
        .check_count     (check_count)
    );

    initial begin
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus table

    task automatic add_step(input int test, input stim_op_e op,
                            input logic [31:0] pc, input logic [31:0] target);
        stim_q.push_back(stim_t'{test, op, pc, target});
    endtask

    task automatic build_table();
        // lookups straight after reset
        add_step(1, STIM_FILL,   32'h0, 32'h0);
        add_step(1, STIM_FILL,   32'h0, 32'h0);
        add_step(1, STIM_LOOKUP, 32'h0000_0100, 32'h0);
        add_step(1, STIM_LOOKUP, 32'h0000_2a48, 32'h0);
        // write then hit with the exact target
        add_step(2, STIM_WRITE,  32'h0000_0100, 32'h1000_0124);
        add_step(2, STIM_WRITE,  32'h0000_0248, 32'h2345_6788);
        add_step(2, STIM_FILL,   32'h0, 32'h0);
        add_step(2, STIM_LOOKUP, 32'h0000_0100, 32'h0);
        add_step(2, STIM_LOOKUP, 32'h0000_0248, 32'h0);
        // same index other tag, then invalidate
        add_step(3, STIM_LOOKUP, 32'h0000_0140, 32'h0);
        add_step(3, STIM_LOOKUP, 32'h0000_0288, 32'h0);
        add_step(3, STIM_INVAL,  32'h0000_0100, 32'h0);
        add_step(3, STIM_FILL,   32'h0, 32'h0);
        add_step(3, STIM_LOOKUP, 32'h0000_0100, 32'h0);
        add_step(3, STIM_LOOKUP, 32'h0000_0248, 32'h0);
        // one shared region, writes two cycles apart
        add_step(4, STIM_WRITE,  32'h0000_0304, 32'h5555_5004);
        add_step(4, STIM_FILL,   32'h0, 32'h0);
        add_step(4, STIM_WRITE,  32'h0000_030c, 32'h5555_53f8);
        add_step(4, STIM_FILL,   32'h0, 32'h0);
        add_step(4, STIM_WRITE,  32'h0000_0310, 32'h5555_5200);
        add_step(4, STIM_IDLE,   32'h0, 32'h0);
        add_step(4, STIM_LOOKUP, 32'h0000_0304, 32'h0);
        add_step(4, STIM_LOOKUP, 32'h0000_030c, 32'h0);
        add_step(4, STIM_LOOKUP, 32'h0000_0310, 32'h0);
        add_step(4, STIM_LOOKUP, 32'h0000_0248, 32'h0);
        // nine new regions overflow the table
        add_step(5, STIM_WRITE,  32'h0000_0414, 32'h6100_0014);
        add_step(5, STIM_WRITE,  32'h0000_0418, 32'h6200_0028);
        add_step(5, STIM_WRITE,  32'h0000_041c, 32'h6300_003c);
        add_step(5, STIM_WRITE,  32'h0000_0420, 32'h6400_0050);
        add_step(5, STIM_WRITE,  32'h0000_0424, 32'h6500_0064);
        add_step(5, STIM_WRITE,  32'h0000_0428, 32'h6600_0078);
        add_step(5, STIM_WRITE,  32'h0000_042c, 32'h6700_008c);
        add_step(5, STIM_WRITE,  32'h0000_0430, 32'h6800_00a0);
        add_step(5, STIM_WRITE,  32'h0000_0434, 32'h6900_00b4);
        add_step(5, STIM_IDLE,   32'h0, 32'h0);
        add_step(5, STIM_LOOKUP, 32'h0000_0248, 32'h0);
        add_step(5, STIM_LOOKUP, 32'h0000_0304, 32'h0);
        add_step(5, STIM_LOOKUP, 32'h0000_0414, 32'h0);
        add_step(5, STIM_LOOKUP, 32'h0000_0434, 32'h0);
        // hits between writes steer the victim choice
        add_step(6, STIM_LOOKUP, 32'h0000_0418, 32'h0);
        add_step(6, STIM_WRITE,  32'h0000_0438, 32'h7100_00c8);
        add_step(6, STIM_LOOKUP, 32'h0000_041c, 32'h0);
        add_step(6, STIM_WRITE,  32'h0000_043c, 32'h7200_00dc);
        add_step(6, STIM_IDLE,   32'h0, 32'h0);
        add_step(6, STIM_LOOKUP, 32'h0000_0418, 32'h0);
        add_step(6, STIM_LOOKUP, 32'h0000_041c, 32'h0);
        add_step(6, STIM_LOOKUP, 32'h0000_0438, 32'h0);
        add_step(6, STIM_LOOKUP, 32'h0000_043c, 32'h0);
    endtask

    // ----------------------------------------
    // drive and report

    task automatic drive_step(input stim_t s);
        logic [31:0] pc;
        pc = s.pc;
        if (s.op == STIM_FILL) begin
            // tag ff is never written
            pc       = $random(seed);
            pc[13:6] = 8'hff;
        end
        req_valid        = (s.op == STIM_LOOKUP) || (s.op == STIM_FILL);
        req_fetch_pc     = pc;
        update_op        = (s.op == STIM_WRITE) ? BTB_OP_WRITE :
                           (s.op == STIM_INVAL) ? BTB_OP_INVALIDATE : BTB_OP_NONE;
        update_fetch_pc  = pc;
        update_target_pc = s.target;
    endtask

    task automatic report_test(input int test);
        int errs;
        int checks;
        errs   = error_count - errors_before;
        checks = check_count - checks_before;
        if (checks == 0) begin
            tests_failed++;
            $display("test %0d failed: no response was checked", test);
        end else if (errs == 0) begin
            tests_passed++;
            $display("test %0d passed, %0d checks", test, checks);
        end else begin
            tests_failed++;
            $display("test %0d failed, %0d of %0d checks wrong", test, errs, checks);
        end
        errors_before = error_count;
        checks_before = check_count;
    endtask

    // one idle cycle lets the last response of the test be checked
    task automatic close_test(input int test);
        drive_step(stim_t'{test, STIM_IDLE, 32'h0, 32'h0});
        @(negedge CLK);
        #1;
        report_test(test);
        @(posedge CLK);
        #2;
    endtask

    initial begin
        nRST             = 1'b0;
        req_valid        = 1'b1;
        req_fetch_pc     = 32'h0000_0100;
        update_op        = BTB_OP_NONE;
        update_fetch_pc  = '0;
        update_target_pc = '0;
        build_table();
        cycle_limit = stim_q.size() + 20;

        repeat (3) @(posedge CLK);
        #2;
        nRST = 1'b1;

        for (int i = 0; i < stim_q.size(); i++) begin
            if (i > 0 && stim_q[i].test != stim_q[i-1].test) begin
                close_test(stim_q[i-1].test);
            end
            drive_step(stim_q[i]);
            @(posedge CLK);
            #2;
        end
        close_test(stim_q[stim_q.size()-1].test);

        $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, check_count, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
